// ==== vlog.f ====
+incdir+design
design/tlp_txresp_pkg.sv
design/rd_req_capture.sv
design/cpl_split_fsm.sv
design/payload_credit.sv
design/cpl_hdr_build.sv
design/tlp_txresp_cntrl.sv
test/tb_tlp_txresp_cntrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the completion splitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_tlp_txresp_cntrl \
  -f vlog.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Test completed successfully" <<< "$sim_out"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== test/tb_tlp_txresp_cntrl.sv ====
`include "txresp_params.svh"

module tb_tlp_txresp_cntrl
  import tlp_txresp_pkg::*;
;

  logic                         avl_clk;
  logic                         rstn;
  logic                         pndg_fifo_empty;
  pndg_rd_t                     pndg_fifo_data;
  logic                         pndg_fifo_rd_req;
  logic                         rd_data_valid;
  logic                         cmd_fifo_busy;
  logic [3:0]                   cmd_fifo_usedw;
  logic [2:0]                   mps;
  cpl_hdr_t                     cpl_hdr;
  logic                         cpl_wr;
  logic [`TXRESP_CPLBUF_AW-1:0] cplbuf_wr_addr;
  logic                         txresp_idle;

  // show-ahead pending-read FIFO and the expected completions
  pndg_rd_t    req_q[$];
  cpl_hdr_t    exp_hdr_q[$];
  int          exp_chunk_q[$];
  bit          exp_last_q[$];
  pndg_rd_t    popped_word;
  logic [31:0] lfsr_state;
  bit          run_en;
  bit          pop_due;
  int          beats_owed;
  int          beats_sent;
  int          cum_bytes;
  int          bp_left;
  int          push_cnt;
  int          pop_cnt;
  int          cpl_cnt;

  tlp_txresp_cntrl u_tlp_txresp_cntrl (
    .AvlClk_i           (avl_clk),
    .Rstn_i             (rstn),
    .pndg_fifo_empty_i  (pndg_fifo_empty),
    .pndg_fifo_data_i   (pndg_fifo_data),
    .pndg_fifo_rd_req_o (pndg_fifo_rd_req),
    .rd_data_valid_i    (rd_data_valid),
    .cmd_fifo_busy_i    (cmd_fifo_busy),
    .cmd_fifo_usedw_i   (cmd_fifo_usedw),
    .mps_i              (mps),
    .cpl_hdr_o          (cpl_hdr),
    .cpl_wr_o           (cpl_wr),
    .cplbuf_wr_addr_o   (cplbuf_wr_addr),
    .txresp_idle_o      (txresp_idle)
  );

  initial
  begin
    avl_clk = 1'b0;
    forever #5 avl_clk = ~avl_clk;
  end

  task automatic fail_now(input string why);
    begin
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    begin
      assert (got == exp)
      else
        fail_now($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    begin
      r = '0;
      for (int i = 0; i < n; i++)
      begin
        r = {r[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
      end
      return r;
    end
  endfunction

  function automatic int lowest_enable(input int be);
    for (int i = 0; i < 4; i++)
    begin
      if (be[i])
        return i;
    end
    return 0;
  endfunction

  // bytes dropped from the head when the enables form one unbroken run
  function automatic int head_drop(input int be);
    int ones;
    int low;
    begin
      if (be == 0)
        return 0;
      ones = $countones(be);
      low  = lowest_enable(be);
      if (be == (((1 << ones) - 1) << low))
        return 4 - ones;
      return 0;
    end
  endfunction

  // bytes dropped from the tail when the enables start at byte 0
  function automatic int tail_drop(input int be);
    for (int n = 1; n < 4; n++)
    begin
      if (be == (1 << n) - 1)
        return 4 - n;
    end
    return 0;
  endfunction

  function automatic pndg_rd_t make_request(input logic [7:0] tag);
    pndg_rd_t    w;
    logic [10:0] dwlen;
    logic [3:0]  lbe;
    begin
      w     = '0;
      dwlen = 11'(rand_bits(8)) + 11'd1;
      lbe   = 4'(rand_bits(4));
      // single dword reads carry no last enables
      if (dwlen == 11'd1)
        lbe = 4'h0;
      w[`TXRESP_PR_TAG_HI:`TXRESP_PR_TAG_LO]     = tag;
      w[`TXRESP_PR_ADDR_HI:`TXRESP_PR_ADDR_LO]   = 5'(rand_bits(5));
      w[`TXRESP_PR_RID_HI:`TXRESP_PR_RID_LO]     = 16'(rand_bits(16));
      w[`TXRESP_PR_DWLEN_HI:`TXRESP_PR_DWLEN_LO] = dwlen;
      w[`TXRESP_PR_FBE_HI:`TXRESP_PR_FBE_LO]     = 4'(rand_bits(4));
      w[`TXRESP_PR_ATTR_HI:`TXRESP_PR_ATTR_LO]   = 2'(rand_bits(2));
      w[`TXRESP_PR_TC_HI:`TXRESP_PR_TC_LO]       = 3'(rand_bits(3));
      w[`TXRESP_PR_LBE_HI:`TXRESP_PR_LBE_LO]     = lbe;
      return w;
    end
  endfunction

  // header holds attr at 95:94, length at 93:85, tc at 84:82, byte count at 81:70,
  // the marker at 68, requester id at 30:15, tag at 14:7 and lower address at 6:0
  task automatic expect_request(input pndg_rd_t word, input logic [2:0] mps_cfg);
    int       remaining;
    int       addr_dw;
    int       to_rcb;
    int       max_bytes;
    int       limit;
    int       chunk;
    int       bcnt;
    int       lower;
    int       fbe;
    int       lbe;
    bit       first;
    cpl_hdr_t hdr;
    begin
      addr_dw   = int'(word[`TXRESP_PR_ADDR_HI:`TXRESP_PR_ADDR_LO]);
      fbe       = int'(word[`TXRESP_PR_FBE_HI:`TXRESP_PR_FBE_LO]);
      lbe       = int'(word[`TXRESP_PR_LBE_HI:`TXRESP_PR_LBE_LO]);
      remaining = int'(word[`TXRESP_PR_DWLEN_HI:`TXRESP_PR_DWLEN_LO]) * 4;
      to_rcb    = `TXRESP_RCB_BYTES - addr_dw * 4;
      max_bytes = (mps_cfg == 3'd0) ? `TXRESP_MPS_SMALL : `TXRESP_MPS_LARGE;
      beats_owed = beats_owed + (remaining + `TXRESP_BEAT_BYTES - 1) / `TXRESP_BEAT_BYTES;
      first = 1'b1;
      while (remaining > 0)
      begin
        limit = first ? to_rcb : max_bytes;
        chunk = (remaining > limit) ? limit : remaining;
        bcnt  = remaining - tail_drop(lbe);
        lower = 0;
        if (first)
        begin
          bcnt = bcnt - head_drop(fbe);
          if (fbe != 0)
            lower = addr_dw * 4 + lowest_enable(fbe);
        end
        hdr        = '0;
        hdr[95:94] = word[`TXRESP_PR_ATTR_HI:`TXRESP_PR_ATTR_LO];
        hdr[93:85] = 9'(chunk / 4);
        hdr[84:82] = word[`TXRESP_PR_TC_HI:`TXRESP_PR_TC_LO];
        hdr[81:70] = 12'(bcnt);
        hdr[68]    = 1'b1;
        hdr[30:15] = word[`TXRESP_PR_RID_HI:`TXRESP_PR_RID_LO];
        hdr[14:7]  = word[`TXRESP_PR_TAG_HI:`TXRESP_PR_TAG_LO];
        hdr[6:0]   = 7'(lower);
        exp_hdr_q.push_back(hdr);
        exp_chunk_q.push_back(chunk);
        exp_last_q.push_back(chunk == remaining);
        remaining = remaining - chunk;
        first = 1'b0;
      end
    end
  endtask

  task automatic check_completion();
    cpl_hdr_t exp_hdr;
    int       chunk;
    int       need;
    bit       last;
    begin
      assert (!cmd_fifo_busy && cmd_fifo_usedw < 4'(`TXRESP_CMD_FIFO_LIMIT))
      else
        fail_now("completion written while the command FIFO was busy or full");
      assert (exp_hdr_q.size() > 0)
      else
        fail_now("completion written with no completion expected");
      exp_hdr = exp_hdr_q.pop_front();
      chunk   = exp_chunk_q.pop_front();
      last    = exp_last_q.pop_front();
      check_hex("cpl_hdr_o length", 32'(cpl_hdr[93:85]), 32'(exp_hdr[93:85]));
      check_hex("cpl_hdr_o byte count", 32'(cpl_hdr[81:70]), 32'(exp_hdr[81:70]));
      check_hex("cpl_hdr_o lower address", 32'(cpl_hdr[6:0]), 32'(exp_hdr[6:0]));
      check_hex("cpl_hdr_o tag", 32'(cpl_hdr[14:7]), 32'(exp_hdr[14:7]));
      check_hex("cpl_hdr_o requester id", 32'(cpl_hdr[30:15]), 32'(exp_hdr[30:15]));
      check_hex("cpl_hdr_o attr", 32'(cpl_hdr[95:94]), 32'(exp_hdr[95:94]));
      check_hex("cpl_hdr_o tc", 32'(cpl_hdr[84:82]), 32'(exp_hdr[84:82]));
      check_hex("cpl_hdr_o marker", 32'(cpl_hdr[68]), 32'(exp_hdr[68]));
      // every byte of the chunk must have come back from Avalon
      need = cum_bytes + chunk;
      assert (beats_sent * `TXRESP_BEAT_BYTES >= need)
      else
        fail_now($sformatf("completion sent with %0d bytes returned but %0d needed",
                           beats_sent * `TXRESP_BEAT_BYTES, need));
      cum_bytes = need;
      if (last)
        cum_bytes = ((cum_bytes + `TXRESP_BEAT_BYTES - 1) / `TXRESP_BEAT_BYTES) *
                    `TXRESP_BEAT_BYTES;
      cpl_cnt++;
    end
  endtask

  task automatic drive_inputs();
    begin
      rd_data_valid = 1'b0;
      if (beats_owed > 0 && rand_bits(2) != 32'd0)
      begin
        rd_data_valid = 1'b1;
        beats_owed--;
        beats_sent++;
      end
      // back-pressure comes in random stretches
      if (bp_left == 0)
      begin
        bp_left       = int'(rand_bits(4));
        cmd_fifo_busy = (rand_bits(2) == 32'd0);
        if (rand_bits(1) == 32'd0)
          cmd_fifo_usedw = 4'(rand_bits(4));
        else
          cmd_fifo_usedw = 4'(rand_bits(3));
      end
      else
        bp_left--;
      pndg_fifo_empty = (req_q.size() == 0);
      pndg_fifo_data  = pndg_fifo_empty ? '0 : req_q[0];
    end
  endtask

  // outputs are sampled before the inputs change on the same falling edge
  always @(negedge avl_clk)
  begin
    if (run_en)
    begin
      if (pop_due)
      begin
        popped_word = req_q.pop_front();
        expect_request(popped_word, mps);
        pop_cnt++;
      end
      if (pndg_fifo_rd_req)
      begin
        assert (!pop_due)
        else
          fail_now("pop request lasted more than one cycle");
        assert (req_q.size() > 0)
        else
          fail_now("pop request while the pending-read FIFO was empty");
      end
      pop_due = pndg_fifo_rd_req;
      if (cpl_wr)
        check_completion();
      check_hex("cplbuf_wr_addr_o", 32'(cplbuf_wr_addr), 32'(beats_sent[8:0]));
      assert (!txresp_idle || pndg_fifo_empty)
      else
        fail_now("idle flag high while the pending-read FIFO held a request");
      drive_inputs();
    end
  end

  function automatic bit drained();
    return (req_q.size() == 0) && (exp_hdr_q.size() == 0);
  endfunction

  task automatic wait_for_drain(input int max_cycles);
    int cycles;
    begin
      cycles = 0;
      while (!drained() && cycles < max_cycles)
      begin
        @(negedge avl_clk);
        cycles++;
      end
      assert (drained())
      else
        fail_now("timed out waiting for the requests to complete");
    end
  endtask

  // the last completion is followed by DONE and then IDLE
  task automatic wait_for_idle(input int max_cycles);
    int cycles;
    begin
      cycles = 0;
      while (!txresp_idle && cycles < max_cycles)
      begin
        @(negedge avl_clk);
        cycles++;
      end
      assert (txresp_idle)
      else
        fail_now("idle flag stayed low after the last completion");
    end
  endtask

  task automatic run_phase(input logic [2:0] mps_cfg, input int n_req);
    int sent;
    int gap;
    begin
      @(negedge avl_clk);
      mps  = mps_cfg;
      sent = 0;
      while (sent < n_req)
      begin
        @(posedge avl_clk);
        req_q.push_back(make_request(8'(push_cnt)));
        push_cnt++;
        sent++;
        // a pause now and then lets the FIFO run empty
        if (rand_bits(2) == 32'd0)
        begin
          gap = int'(rand_bits(7));
          repeat (gap) @(posedge avl_clk);
        end
      end
      wait_for_drain(200000);
      wait_for_idle(8);
    end
  endtask

  initial
  begin
    rstn            = 1'b0;
    pndg_fifo_empty = 1'b1;
    pndg_fifo_data  = '0;
    rd_data_valid   = 1'b0;
    cmd_fifo_busy   = 1'b0;
    cmd_fifo_usedw  = 4'h0;
    mps             = 3'd0;
    lfsr_state      = 32'hf6b9420a;
    run_en          = 1'b0;
    pop_due         = 1'b0;
    beats_owed      = 0;
    beats_sent      = 0;
    cum_bytes       = 0;
    bp_left         = 0;
    push_cnt        = 0;
    pop_cnt         = 0;
    cpl_cnt         = 0;
    repeat (2) @(posedge avl_clk);
    @(negedge avl_clk);
    rstn = 1'b1;
    @(negedge avl_clk);
    check_hex("cpl_wr_o", 32'(cpl_wr), 32'd0);
    check_hex("pndg_fifo_rd_req_o", 32'(pndg_fifo_rd_req), 32'd0);
    check_hex("txresp_idle_o", 32'(txresp_idle), 32'd1);
    check_hex("cplbuf_wr_addr_o", 32'(cplbuf_wr_addr), 32'd0);
    run_en = 1'b1;
    // 128 byte and 256 byte max payload
    run_phase(3'd0, 48);
    run_phase(3'd1, 48);
    $display("%0d requests split into %0d completions", pop_cnt, cpl_cnt);
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== design/tlp_txresp_cntrl.sv ====
`include "txresp_params.svh"

module tlp_txresp_cntrl
  import tlp_txresp_pkg::*;
(
  input  logic                         AvlClk_i,
  input  logic                         Rstn_i,
  input  logic                         pndg_fifo_empty_i,
  input  pndg_rd_t                     pndg_fifo_data_i,
  output logic                         pndg_fifo_rd_req_o,
  input  logic                         rd_data_valid_i,
  input  logic                         cmd_fifo_busy_i,
  input  logic [3:0]                   cmd_fifo_usedw_i,
  input  logic [2:0]                   mps_i,
  output cpl_hdr_t                     cpl_hdr_o,
  output logic                         cpl_wr_o,
  output logic [`TXRESP_CPLBUF_AW-1:0] cplbuf_wr_addr_o,
  output logic                         txresp_idle_o
);

  logic         ld_req;
  logic         load_bcnt;
  logic         first_cpl;
  logic         chunk_req;
  logic         chunk_sent;
  logic         req_done;
  logic         data_ready;
  dwlen_t       dwlen;
  bcnt_t        bytes_to_rcb;
  bcnt_t        be_mask_bytes;
  bcnt_t        chunk_bytes;
  bcnt_t        remain_bytes;
  bcnt_t        send_bytes;
  lower_addr_t  lower_addr;
  logic [7:0]   tag;
  logic [15:0]  requester_id;
  logic [1:0]   attr;
  logic [2:0]   tc;
  cplbuf_addr_t cplbuf_addr;

  rd_req_capture u_rd_req_capture (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .ld_req_i         (ld_req),
    .first_cpl_i      (first_cpl),
    .pndg_fifo_data_i (pndg_fifo_data_i),
    .dwlen_o          (dwlen),
    .bytes_to_rcb_o   (bytes_to_rcb),
    .lower_addr_o     (lower_addr),
    .be_mask_bytes_o  (be_mask_bytes),
    .tag_o            (tag),
    .requester_id_o   (requester_id),
    .attr_o           (attr),
    .tc_o             (tc)
  );

  cpl_split_fsm u_cpl_split_fsm (
    .AvlClk_i           (AvlClk_i),
    .Rstn_i             (Rstn_i),
    .pndg_fifo_empty_i  (pndg_fifo_empty_i),
    .cmd_fifo_busy_i    (cmd_fifo_busy_i),
    .cmd_fifo_usedw_i   (cmd_fifo_usedw_i),
    .mps_i              (mps_i),
    .dwlen_i            (dwlen),
    .bytes_to_rcb_i     (bytes_to_rcb),
    .be_mask_bytes_i    (be_mask_bytes),
    .data_ready_i       (data_ready),
    .pndg_fifo_rd_req_o (pndg_fifo_rd_req_o),
    .ld_req_o           (ld_req),
    .load_bcnt_o        (load_bcnt),
    .first_cpl_o        (first_cpl),
    .chunk_req_o        (chunk_req),
    .chunk_bytes_o      (chunk_bytes),
    .chunk_sent_o       (chunk_sent),
    .req_done_o         (req_done),
    .remain_bytes_o     (remain_bytes),
    .send_bytes_o       (send_bytes),
    .cpl_wr_o           (cpl_wr_o),
    .txresp_idle_o      (txresp_idle_o)
  );

  payload_credit u_payload_credit (
    .AvlClk_i         (AvlClk_i),
    .Rstn_i           (Rstn_i),
    .rd_data_valid_i  (rd_data_valid_i),
    .chunk_req_i      (chunk_req),
    .chunk_bytes_i    (chunk_bytes),
    .chunk_sent_i     (chunk_sent),
    .req_done_i       (req_done),
    .data_ready_o     (data_ready),
    .cplbuf_wr_addr_o (cplbuf_addr)
  );

  cpl_hdr_build u_cpl_hdr_build (
    .AvlClk_i       (AvlClk_i),
    .Rstn_i         (Rstn_i),
    .load_bcnt_i    (load_bcnt),
    .first_cpl_i    (first_cpl),
    .lower_addr_i   (lower_addr),
    .send_bytes_i   (send_bytes),
    .remain_bytes_i (remain_bytes),
    .tag_i          (tag),
    .requester_id_i (requester_id),
    .attr_i         (attr),
    .tc_i           (tc),
    .cpl_hdr_o      (cpl_hdr_o)
  );

  assign cplbuf_wr_addr_o = cplbuf_addr;

endmodule

// ==== design/cpl_hdr_build.sv ====
module cpl_hdr_build
  import tlp_txresp_pkg::*;
(
  input  logic        AvlClk_i,
  input  logic        Rstn_i,
  input  logic        load_bcnt_i,
  input  logic        first_cpl_i,
  input  lower_addr_t lower_addr_i,
  input  bcnt_t       send_bytes_i,
  input  bcnt_t       remain_bytes_i,
  input  logic [7:0]  tag_i,
  input  logic [15:0] requester_id_i,
  input  logic [1:0]  attr_i,
  input  logic [2:0]  tc_i,
  output cpl_hdr_t    cpl_hdr_o
);

  lower_addr_t lower_addr_q;
  logic [8:0]  dw_len;

  // only the first completion carries a non-zero lower address
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      lower_addr_q <= '0;
    else if (load_bcnt_i)
      lower_addr_q <= lower_addr_i;
    else if (!first_cpl_i)
      lower_addr_q <= '0;
  end

  assign dw_len = send_bytes_i[10:2];

  // flush and unsupported-size bits stay 0
  assign cpl_hdr_o = {3'b000,
                      attr_i,
                      dw_len,
                      tc_i,
                      remain_bytes_i[11:0],
                      1'b0,
                      1'b1,
                      4'h0,
                      32'h0,
                      1'b0,
                      requester_id_i,
                      tag_i,
                      lower_addr_q};

endmodule

// ==== design/payload_credit.sv ====
`include "txresp_params.svh"

module payload_credit
  import tlp_txresp_pkg::*;
(
  input  logic         AvlClk_i,
  input  logic         Rstn_i,
  input  logic         rd_data_valid_i,
  input  logic         chunk_req_i,
  input  bcnt_t        chunk_bytes_i,
  input  logic         chunk_sent_i,
  input  logic         req_done_i,
  output logic         data_ready_o,
  output cplbuf_addr_t cplbuf_wr_addr_o
);

  credit_t limit_q;
  credit_t consumed_q;
  credit_t required_q;
  credit_t consumed_rnd;
  credit_t available;

  // bytes returned from Avalon, one beat at a time
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      limit_q <= '0;
    else if (rd_data_valid_i)
      limit_q <= limit_q + credit_t'(`TXRESP_BEAT_BYTES);
  end

  // unused tail of the last beat of a request is dropped
  assign consumed_rnd = (consumed_q + credit_t'(`TXRESP_BEAT_BYTES - 1)) &
                        ~credit_t'(`TXRESP_BEAT_BYTES - 1);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      consumed_q <= '0;
    else if (chunk_sent_i)
      consumed_q <= consumed_q + credit_t'(chunk_bytes_i);
    else if (req_done_i)
      consumed_q <= consumed_rnd;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      required_q <= '0;
    else if (chunk_req_i)
      required_q <= consumed_q + credit_t'(chunk_bytes_i);
  end

  // a short limit wraps the difference far above the window
  assign available = limit_q - required_q;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      data_ready_o <= 1'b0;
    else
      data_ready_o <= !chunk_req_i && (available <= credit_t'(`TXRESP_CREDIT_WINDOW));
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      cplbuf_wr_addr_o <= '0;
    else if (rd_data_valid_i)
      cplbuf_wr_addr_o <= cplbuf_wr_addr_o + 1'b1;
  end

endmodule

// ==== design/cpl_split_fsm.sv ====
`include "txresp_params.svh"

module cpl_split_fsm
  import tlp_txresp_pkg::*;
(
  input  logic       AvlClk_i,
  input  logic       Rstn_i,
  input  logic       pndg_fifo_empty_i,
  input  logic       cmd_fifo_busy_i,
  input  logic [3:0] cmd_fifo_usedw_i,
  input  logic [2:0] mps_i,
  input  dwlen_t     dwlen_i,
  input  bcnt_t      bytes_to_rcb_i,
  input  bcnt_t      be_mask_bytes_i,
  input  logic       data_ready_i,
  output logic       pndg_fifo_rd_req_o,
  output logic       ld_req_o,
  output logic       load_bcnt_o,
  output logic       first_cpl_o,
  output logic       chunk_req_o,
  output bcnt_t      chunk_bytes_o,
  output logic       chunk_sent_o,
  output logic       req_done_o,
  output bcnt_t      remain_bytes_o,
  output bcnt_t      send_bytes_o,
  output logic       cpl_wr_o,
  output logic       txresp_idle_o
);

  split_state_t state_q;
  split_state_t state_d;
  bcnt_t        curr_bcnt_q;
  bcnt_t        max_payload;
  bcnt_t        chunk_q;
  logic         first_q;
  logic         cmd_fifo_ok;

  assign cmd_fifo_ok = !cmd_fifo_busy_i &&
                       (cmd_fifo_usedw_i < 4'(`TXRESP_CMD_FIFO_LIMIT));

  // device control max payload size, code 0 is 128 bytes
  assign max_payload = (mps_i == 3'd0) ? bcnt_t'(`TXRESP_MPS_SMALL) :
                                         bcnt_t'(`TXRESP_MPS_LARGE);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (!pndg_fifo_empty_i)
          state_d = RD_FIFO;
      RD_FIFO:
        state_d = LD_BCNT;
      LD_BCNT:
        state_d = WAIT_DATA;
      WAIT_DATA:
      begin
        if (cmd_fifo_ok)
        begin
          if (first_q)
            state_d = (curr_bcnt_q > bytes_to_rcb_i) ? WAIT_FIRST : WAIT_LAST;
          else
            state_d = (curr_bcnt_q > max_payload) ? WAIT_MAX : WAIT_LAST;
        end
      end
      WAIT_FIRST:
        state_d = PIPE_FIRST;
      WAIT_MAX:
        state_d = PIPE_MAX;
      WAIT_LAST:
        state_d = PIPE_LAST;
      PIPE_FIRST:
        if (data_ready_i && cmd_fifo_ok)
          state_d = SEND_FIRST;
      PIPE_MAX:
        if (data_ready_i && cmd_fifo_ok)
          state_d = SEND_MAX;
      PIPE_LAST:
        if (data_ready_i && cmd_fifo_ok)
          state_d = SEND_LAST;
      SEND_FIRST:
        state_d = WAIT_DATA;
      SEND_MAX:
        state_d = (curr_bcnt_q == max_payload) ? DONE : WAIT_DATA;
      SEND_LAST:
        state_d = DONE;
      DONE:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  // bytes of the request still to be completed
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      curr_bcnt_q <= '0;
    else if (state_q == LD_BCNT)
      curr_bcnt_q <= {dwlen_i, 2'b00};
    else if (state_q == SEND_FIRST)
      curr_bcnt_q <= curr_bcnt_q - bytes_to_rcb_i;
    else if (state_q == SEND_MAX)
      curr_bcnt_q <= curr_bcnt_q - max_payload;
    else if (state_q == SEND_LAST)
      curr_bcnt_q <= '0;
  end

  // size of the chunk picked in WAIT_DATA, held until it is sent
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      chunk_q <= '0;
    else if (state_q == WAIT_DATA)
    begin
      case (state_d)
        WAIT_FIRST: chunk_q <= bytes_to_rcb_i;
        WAIT_MAX:   chunk_q <= max_payload;
        WAIT_LAST:  chunk_q <= curr_bcnt_q;
        default:    chunk_q <= chunk_q;
      endcase
    end
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      first_q <= 1'b0;
    else if (state_q == LD_BCNT)
      first_q <= 1'b1;
    else if (state_q == SEND_FIRST || state_q == DONE)
      first_q <= 1'b0;
  end

  // byte count field of the header
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      remain_bytes_o <= '0;
    else
      remain_bytes_o <= curr_bcnt_q - be_mask_bytes_i;
  end

  assign pndg_fifo_rd_req_o = (state_q == RD_FIFO);
  assign ld_req_o           = (state_q == RD_FIFO);
  assign load_bcnt_o        = (state_q == LD_BCNT);
  assign first_cpl_o        = load_bcnt_o | first_q;

  assign chunk_req_o   = (state_q == WAIT_FIRST) || (state_q == WAIT_MAX) ||
                         (state_q == WAIT_LAST);
  assign cpl_wr_o      = (state_q == SEND_FIRST) || (state_q == SEND_MAX) ||
                         (state_q == SEND_LAST);
  assign chunk_sent_o  = cpl_wr_o;
  assign chunk_bytes_o = chunk_q;
  assign send_bytes_o  = cpl_wr_o ? chunk_q : '0;
  assign req_done_o    = (state_q == DONE);

  assign txresp_idle_o = (state_q == IDLE) && pndg_fifo_empty_i;

endmodule

// ==== design/rd_req_capture.sv ====
`include "txresp_params.svh"

module rd_req_capture
  import tlp_txresp_pkg::*;
(
  input  logic        AvlClk_i,
  input  logic        Rstn_i,
  input  logic        ld_req_i,
  input  logic        first_cpl_i,
  input  pndg_rd_t    pndg_fifo_data_i,
  output dwlen_t      dwlen_o,
  output bcnt_t       bytes_to_rcb_o,
  output lower_addr_t lower_addr_o,
  output bcnt_t       be_mask_bytes_o,
  output logic [7:0]  tag_o,
  output logic [15:0] requester_id_o,
  output logic [1:0]  attr_o,
  output logic [2:0]  tc_o
);

  logic [4:0] addr_q;
  be_t        fbe_q;
  be_t        lbe_q;
  logic [1:0] fbe_ofs;
  bcnt_t      fbe_mask;
  bcnt_t      lbe_mask;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      dwlen_o <= '0;
      addr_q  <= '0;
      fbe_q   <= '0;
      lbe_q   <= '0;
    end
    else if (ld_req_i)
    begin
      dwlen_o <= pndg_fifo_data_i[`TXRESP_PR_DWLEN_HI:`TXRESP_PR_DWLEN_LO];
      addr_q  <= pndg_fifo_data_i[`TXRESP_PR_ADDR_HI:`TXRESP_PR_ADDR_LO];
      fbe_q   <= pndg_fifo_data_i[`TXRESP_PR_FBE_HI:`TXRESP_PR_FBE_LO];
      lbe_q   <= pndg_fifo_data_i[`TXRESP_PR_LBE_HI:`TXRESP_PR_LBE_LO];
    end
  end

  // header-only fields
  always_ff @(posedge AvlClk_i)
  begin
    if (ld_req_i)
    begin
      tag_o          <= pndg_fifo_data_i[`TXRESP_PR_TAG_HI:`TXRESP_PR_TAG_LO];
      requester_id_o <= pndg_fifo_data_i[`TXRESP_PR_RID_HI:`TXRESP_PR_RID_LO];
      attr_o         <= pndg_fifo_data_i[`TXRESP_PR_ATTR_HI:`TXRESP_PR_ATTR_LO];
      tc_o           <= pndg_fifo_data_i[`TXRESP_PR_TC_HI:`TXRESP_PR_TC_LO];
    end
  end

  // distance from the dword-aligned start to the next 128-byte boundary
  assign bytes_to_rcb_o = bcnt_t'(`TXRESP_RCB_BYTES) - bcnt_t'({addr_q, 2'b00});

  // byte offset of the lowest enabled byte in the first dword
  always_comb
  begin
    if (fbe_q[0])
      fbe_ofs = 2'd0;
    else if (fbe_q[1])
      fbe_ofs = 2'd1;
    else if (fbe_q[2])
      fbe_ofs = 2'd2;
    else
      fbe_ofs = 2'd3;
  end

  // zero-length read reports lower address 0
  assign lower_addr_o = (fbe_q == 4'b0000) ? '0 : {addr_q, fbe_ofs};

  // disabled bytes at the head, counted only for the first completion
  always_comb
  begin
    fbe_mask = '0;
    if (first_cpl_i)
    begin
      case (fbe_q)
        4'b0001, 4'b0010, 4'b0100, 4'b1000: fbe_mask = 13'd3;
        4'b0011, 4'b0110, 4'b1100:          fbe_mask = 13'd2;
        4'b0111, 4'b1110:                   fbe_mask = 13'd1;
        default:                            fbe_mask = '0;
      endcase
    end
  end

  // disabled bytes at the tail
  always_comb
  begin
    case (lbe_q)
      4'b0111: lbe_mask = 13'd1;
      4'b0011: lbe_mask = 13'd2;
      4'b0001: lbe_mask = 13'd3;
      default: lbe_mask = '0;
    endcase
  end

  assign be_mask_bytes_o = fbe_mask + lbe_mask;

endmodule

// ==== design/tlp_txresp_pkg.sv ====
`include "txresp_params.svh"

package tlp_txresp_pkg;

  typedef logic [`TXRESP_PNDG_W-1:0]    pndg_rd_t;
  typedef logic [`TXRESP_HDR_W-1:0]     cpl_hdr_t;
  typedef logic [12:0]                  bcnt_t;
  typedef logic [10:0]                  dwlen_t;
  typedef logic [6:0]                   lower_addr_t;
  typedef logic [3:0]                   be_t;

  // credit counters wrap, the window compare is done modulo 2048
  typedef logic [10:0]                  credit_t;
  typedef logic [`TXRESP_CPLBUF_AW-1:0] cplbuf_addr_t;

  typedef enum logic [3:0] {
    IDLE,
    RD_FIFO,
    LD_BCNT,
    WAIT_DATA,
    WAIT_FIRST,
    WAIT_MAX,
    WAIT_LAST,
    PIPE_FIRST,
    PIPE_MAX,
    PIPE_LAST,
    SEND_FIRST,
    SEND_MAX,
    SEND_LAST,
    DONE
  } split_state_t;

endpackage

// ==== design/txresp_params.svh ====
`ifndef TXRESP_PARAMS_SVH
`define TXRESP_PARAMS_SVH

// widths of the pending-read word and the completion header
`define TXRESP_PNDG_W           57
`define TXRESP_HDR_W            99

// split limits in bytes
`define TXRESP_RCB_BYTES        128
`define TXRESP_MPS_SMALL        128
`define TXRESP_MPS_LARGE        256

// credit accounting
`define TXRESP_BEAT_BYTES       16
`define TXRESP_CREDIT_WINDOW    1024

// command FIFO fill level that stops new completions
`define TXRESP_CMD_FIFO_LIMIT   8

// completion buffer address width
`define TXRESP_CPLBUF_AW        9

// pending-read word fields
`define TXRESP_PR_TAG_HI        7
`define TXRESP_PR_TAG_LO        0
`define TXRESP_PR_ADDR_HI       14
`define TXRESP_PR_ADDR_LO       10
`define TXRESP_PR_RID_HI        31
`define TXRESP_PR_RID_LO        16
`define TXRESP_PR_DWLEN_HI      42
`define TXRESP_PR_DWLEN_LO      32
`define TXRESP_PR_FBE_HI        46
`define TXRESP_PR_FBE_LO        43
`define TXRESP_PR_ATTR_HI       48
`define TXRESP_PR_ATTR_LO       47
`define TXRESP_PR_TC_HI         51
`define TXRESP_PR_TC_LO         49
`define TXRESP_PR_LBE_HI        55
`define TXRESP_PR_LBE_LO        52

`endif
